// File: hw/gpio_pkg.sv
`default_nettype none

package gpio_pkg;

  // Pin count of the block
  localparam int NumGpio = 32;

  // Pins covered by one masked output register
  localparam int HalfGpio = NumGpio / 2;

  // One bit per pin
  typedef logic [NumGpio-1:0] gpio_vec_t;

endpackage

`default_nettype wire

// File: hw/gpio_reg_pkg.sv
`default_nettype none

package gpio_reg_pkg;

  // Bus widths
  localparam int RegAw = 6;
  localparam int RegDw = 32;
  localparam int RegBw = RegDw / 8;

  typedef logic [RegDw-1:0] reg_word_t;
  typedef logic [RegAw-1:0] reg_addr_t;

  // Register index, also the bit position in the strobe vector
  typedef enum int unsigned {
    INTR_STATE       = 0,
    INTR_ENABLE      = 1,
    INTR_TEST        = 2,
    DATA_IN          = 3,
    DIRECT_OUT       = 4,
    MASKED_OUT_LOWER = 5,
    MASKED_OUT_UPPER = 6,
    DIRECT_OE        = 7,
    INTR_RISING      = 8,
    INTR_FALLING     = 9
  } reg_idx_e;

  localparam int NumRegs = 10;

  typedef logic [NumRegs-1:0] reg_onehot_t;

  // Byte offsets
  localparam reg_addr_t GPIO_INTR_STATE_OFFSET       = 6'h00;
  localparam reg_addr_t GPIO_INTR_ENABLE_OFFSET      = 6'h04;
  localparam reg_addr_t GPIO_INTR_TEST_OFFSET        = 6'h08;
  localparam reg_addr_t GPIO_DATA_IN_OFFSET          = 6'h0c;
  localparam reg_addr_t GPIO_DIRECT_OUT_OFFSET       = 6'h10;
  localparam reg_addr_t GPIO_MASKED_OUT_LOWER_OFFSET = 6'h14;
  localparam reg_addr_t GPIO_MASKED_OUT_UPPER_OFFSET = 6'h18;
  localparam reg_addr_t GPIO_DIRECT_OE_OFFSET        = 6'h1c;
  localparam reg_addr_t GPIO_INTR_RISING_OFFSET      = 6'h20;
  localparam reg_addr_t GPIO_INTR_FALLING_OFFSET     = 6'h24;

  // Masked output word, mask in the upper half and data in the lower
  typedef union packed {
    reg_word_t raw;
    struct packed {
      logic [gpio_pkg::HalfGpio-1:0] mask;
      logic [gpio_pkg::HalfGpio-1:0] data;
    } fields;
  } masked_word_t;

endpackage

`default_nettype wire

// File: hw/gpio_reg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface gpio_reg_if (
  input logic clk_i
);

  // Decoder to function blocks
  gpio_reg_pkg::reg_word_t   wdata;
  gpio_reg_pkg::reg_onehot_t wr_en;

  // Register contents back to the read mux
  gpio_pkg::gpio_vec_t out_q;
  gpio_pkg::gpio_vec_t oe_q;
  gpio_pkg::gpio_vec_t data_in_q;
  gpio_pkg::gpio_vec_t state_q;
  gpio_pkg::gpio_vec_t enable_q;
  gpio_pkg::gpio_vec_t rising_q;
  gpio_pkg::gpio_vec_t falling_q;

  modport decode (
    input  clk_i,
    output wdata, wr_en,
    input  out_q, oe_q, data_in_q, state_q, enable_q, rising_q, falling_q
  );

  modport out_ctrl (input wdata, wr_en, output out_q, oe_q);

  modport in_sync (output data_in_q);

  modport intr (input wdata, wr_en, output state_q, enable_q, rising_q, falling_q);

endinterface

`default_nettype wire

// File: hw/gpio_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_reg_decode (
  input  logic                           reg_we_i,
  input  logic                           reg_re_i,
  input  gpio_reg_pkg::reg_addr_t        reg_addr_i,
  input  gpio_reg_pkg::reg_word_t        reg_wdata_i,
  input  logic [gpio_reg_pkg::RegBw-1:0] reg_be_i,
  output gpio_reg_pkg::reg_word_t        reg_rdata_o,
  output logic                           reg_error_o,
  gpio_reg_if.decode                     bus
);

  gpio_reg_pkg::reg_onehot_t    addr_hit;
  logic                         addr_miss;
  logic                         be_err;
  gpio_reg_pkg::masked_word_t   rd_lower;
  gpio_reg_pkg::masked_word_t   rd_upper;

  always_comb begin
    addr_hit = '0;
    addr_hit[gpio_reg_pkg::INTR_STATE] =
        (reg_addr_i == gpio_reg_pkg::GPIO_INTR_STATE_OFFSET);
    addr_hit[gpio_reg_pkg::INTR_ENABLE] =
        (reg_addr_i == gpio_reg_pkg::GPIO_INTR_ENABLE_OFFSET);
    addr_hit[gpio_reg_pkg::INTR_TEST] =
        (reg_addr_i == gpio_reg_pkg::GPIO_INTR_TEST_OFFSET);
    addr_hit[gpio_reg_pkg::DATA_IN] =
        (reg_addr_i == gpio_reg_pkg::GPIO_DATA_IN_OFFSET);
    addr_hit[gpio_reg_pkg::DIRECT_OUT] =
        (reg_addr_i == gpio_reg_pkg::GPIO_DIRECT_OUT_OFFSET);
    addr_hit[gpio_reg_pkg::MASKED_OUT_LOWER] =
        (reg_addr_i == gpio_reg_pkg::GPIO_MASKED_OUT_LOWER_OFFSET);
    addr_hit[gpio_reg_pkg::MASKED_OUT_UPPER] =
        (reg_addr_i == gpio_reg_pkg::GPIO_MASKED_OUT_UPPER_OFFSET);
    addr_hit[gpio_reg_pkg::DIRECT_OE] =
        (reg_addr_i == gpio_reg_pkg::GPIO_DIRECT_OE_OFFSET);
    addr_hit[gpio_reg_pkg::INTR_RISING] =
        (reg_addr_i == gpio_reg_pkg::GPIO_INTR_RISING_OFFSET);
    addr_hit[gpio_reg_pkg::INTR_FALLING] =
        (reg_addr_i == gpio_reg_pkg::GPIO_INTR_FALLING_OFFSET);
  end

  // Misses error on either strobe, partial writes only on a write
  assign addr_miss   = (reg_we_i | reg_re_i) & ~|addr_hit;
  assign be_err      = reg_we_i & ~&reg_be_i;
  assign reg_error_o = addr_miss | be_err;

  // Errored writes never reach a register
  assign bus.wdata = reg_wdata_i;
  assign bus.wr_en = addr_hit & {gpio_reg_pkg::NumRegs{reg_we_i & ~reg_error_o}};

  // Masked registers read back the current output half, mask as zero
  always_comb begin
    rd_lower.fields.mask = '0;
    rd_lower.fields.data = bus.out_q[gpio_pkg::HalfGpio-1:0];
    rd_upper.fields.mask = '0;
    rd_upper.fields.data = bus.out_q[gpio_pkg::NumGpio-1:gpio_pkg::HalfGpio];
  end

  always_comb begin
    unique case (1'b1)
      addr_hit[gpio_reg_pkg::INTR_STATE]:       reg_rdata_o = bus.state_q;
      addr_hit[gpio_reg_pkg::INTR_ENABLE]:      reg_rdata_o = bus.enable_q;
      addr_hit[gpio_reg_pkg::INTR_TEST]:        reg_rdata_o = '0;
      addr_hit[gpio_reg_pkg::DATA_IN]:          reg_rdata_o = bus.data_in_q;
      addr_hit[gpio_reg_pkg::DIRECT_OUT]:       reg_rdata_o = bus.out_q;
      addr_hit[gpio_reg_pkg::MASKED_OUT_LOWER]: reg_rdata_o = rd_lower.raw;
      addr_hit[gpio_reg_pkg::MASKED_OUT_UPPER]: reg_rdata_o = rd_upper.raw;
      addr_hit[gpio_reg_pkg::DIRECT_OE]:        reg_rdata_o = bus.oe_q;
      addr_hit[gpio_reg_pkg::INTR_RISING]:      reg_rdata_o = bus.rising_q;
      addr_hit[gpio_reg_pkg::INTR_FALLING]:     reg_rdata_o = bus.falling_q;
      default:                                  reg_rdata_o = '1;
    endcase
  end

  // Offsets must stay distinct for the one-hot read mux
  a_addr_hit_onehot0: assert property (
    @(posedge bus.clk_i) (reg_we_i || reg_re_i) |-> $onehot0(addr_hit)
  );

endmodule

`default_nettype wire

// File: hw/gpio_out_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_out_ctrl (
  input  logic                clk_i,
  input  logic                rst_n_i,
  gpio_reg_if.out_ctrl        bus,
  output gpio_pkg::gpio_vec_t gpio_o,
  output gpio_pkg::gpio_vec_t gpio_oe_o
);

  localparam int H = gpio_pkg::HalfGpio;
  localparam int N = gpio_pkg::NumGpio;

  gpio_reg_pkg::masked_word_t masked_wd;
  gpio_pkg::gpio_vec_t        out_d;

  // Take data where the mask is set, keep the old bit elsewhere
  function automatic logic [H-1:0] merge_half(
    input logic [H-1:0]              old_bits,
    input gpio_reg_pkg::masked_word_t word
  );
    return (word.fields.data & word.fields.mask) | (old_bits & ~word.fields.mask);
  endfunction

  assign masked_wd.raw = bus.wdata;

  always_comb begin
    out_d = bus.out_q;
    if (bus.wr_en[gpio_reg_pkg::DIRECT_OUT]) begin
      out_d = bus.wdata;
    end
    if (bus.wr_en[gpio_reg_pkg::MASKED_OUT_LOWER]) begin
      out_d[H-1:0] = merge_half(bus.out_q[H-1:0], masked_wd);
    end
    if (bus.wr_en[gpio_reg_pkg::MASKED_OUT_UPPER]) begin
      out_d[N-1:H] = merge_half(bus.out_q[N-1:H], masked_wd);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bus.out_q <= '0;
      bus.oe_q  <= '0;
    end else begin
      bus.out_q <= out_d;
      if (bus.wr_en[gpio_reg_pkg::DIRECT_OE]) begin
        bus.oe_q <= bus.wdata;
      end
    end
  end

  assign gpio_o    = bus.out_q;
  assign gpio_oe_o = bus.oe_q;

  // Decoder hands out at most one output strobe per cycle
  a_out_strobe_onehot0: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({bus.wr_en[gpio_reg_pkg::DIRECT_OUT],
              bus.wr_en[gpio_reg_pkg::MASKED_OUT_LOWER],
              bus.wr_en[gpio_reg_pkg::MASKED_OUT_UPPER]})
  );

endmodule

`default_nettype wire

// File: hw/gpio_in_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_in_sync #(
  parameter int SyncStages = 2
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  gpio_pkg::gpio_vec_t gpio_i,
  gpio_reg_if.in_sync         bus,
  output gpio_pkg::gpio_vec_t sync_o
);

  // Stage 0 samples the pins, the top stage is the settled value
  gpio_pkg::gpio_vec_t [SyncStages-1:0] sync_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[SyncStages-2:0], gpio_i};
    end
  end

  assign bus.data_in_q = sync_q[SyncStages-1];
  assign sync_o        = sync_q[SyncStages-1];

endmodule

`default_nettype wire

// File: hw/gpio_intr.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_intr (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  gpio_pkg::gpio_vec_t sync_i,
  gpio_reg_if.intr            bus,
  output gpio_pkg::gpio_vec_t intr_o
);

  gpio_pkg::gpio_vec_t prev_q;
  gpio_pkg::gpio_vec_t edge_evt;
  gpio_pkg::gpio_vec_t set_bits;
  gpio_pkg::gpio_vec_t clr_bits;

  // Edge events gated by their own enables
  assign edge_evt = (sync_i & ~prev_q & bus.rising_q) |
                    (~sync_i & prev_q & bus.falling_q);

  assign set_bits = edge_evt |
                    (bus.wr_en[gpio_reg_pkg::INTR_TEST] ? bus.wdata : '0);
  assign clr_bits = bus.wr_en[gpio_reg_pkg::INTR_STATE] ? bus.wdata : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prev_q        <= '0;
      bus.state_q   <= '0;
      bus.enable_q  <= '0;
      bus.rising_q  <= '0;
      bus.falling_q <= '0;
    end else begin
      prev_q      <= sync_i;
      // New events win over a clear
      bus.state_q <= (bus.state_q & ~clr_bits) | set_bits;
      if (bus.wr_en[gpio_reg_pkg::INTR_ENABLE]) begin
        bus.enable_q <= bus.wdata;
      end
      if (bus.wr_en[gpio_reg_pkg::INTR_RISING]) begin
        bus.rising_q <= bus.wdata;
      end
      if (bus.wr_en[gpio_reg_pkg::INTR_FALLING]) begin
        bus.falling_q <= bus.wdata;
      end
    end
  end

  assign intr_o = bus.state_q & bus.enable_q;

  // A state bit only rises after a change on an edge-enabled pin or a test write
  a_state_rise_has_cause: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (bus.state_q & ~$past(bus.state_q) &
     ~$past((sync_i ^ prev_q) & (bus.rising_q | bus.falling_q)) &
     ~$past(bus.wr_en[gpio_reg_pkg::INTR_TEST] ? bus.wdata : '0)) == '0
  );

endmodule

`default_nettype wire

// File: hw/gpio_top.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_top #(
  parameter int SyncStages = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           reg_we_i,
  input  logic                           reg_re_i,
  input  gpio_reg_pkg::reg_addr_t        reg_addr_i,
  input  gpio_reg_pkg::reg_word_t        reg_wdata_i,
  input  logic [gpio_reg_pkg::RegBw-1:0] reg_be_i,
  output gpio_reg_pkg::reg_word_t        reg_rdata_o,
  output logic                           reg_error_o,
  input  gpio_pkg::gpio_vec_t            gpio_i,
  output gpio_pkg::gpio_vec_t            gpio_o,
  output gpio_pkg::gpio_vec_t            gpio_oe_o,
  output gpio_pkg::gpio_vec_t            intr_o
);

  // Synchronized pins into the edge detector
  gpio_pkg::gpio_vec_t sync_pins;

  gpio_reg_if u_reg_if (
    .clk_i (clk_i)
  );

  gpio_reg_decode u_decode (
    .reg_we_i    (reg_we_i),
    .reg_re_i    (reg_re_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_be_i    (reg_be_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_error_o (reg_error_o),
    .bus         (u_reg_if.decode)
  );

  gpio_out_ctrl u_out_ctrl (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .bus       (u_reg_if.out_ctrl),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o)
  );

  gpio_in_sync #(
    .SyncStages (SyncStages)
  ) u_in_sync (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .gpio_i  (gpio_i),
    .bus     (u_reg_if.in_sync),
    .sync_o  (sync_pins)
  );

  gpio_intr u_intr (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .sync_i  (sync_pins),
    .bus     (u_reg_if.intr),
    .intr_o  (intr_o)
  );

endmodule

`default_nettype wire

// File: testbench/tb_gpio_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gpio_top;

  typedef enum logic [1:0] {
    OP_RD,
    OP_WR,
    OP_PIN
  } op_e;

  // One table step plus the pin state expected while it is on the bus
  typedef struct {
    op_e                            op;
    gpio_reg_pkg::reg_addr_t        addr;
    gpio_reg_pkg::reg_word_t        wdata;
    logic [gpio_reg_pkg::RegBw-1:0] be;
    gpio_pkg::gpio_vec_t            pins;
    gpio_reg_pkg::reg_word_t        exp_rdata;
    logic                           exp_err;
    gpio_pkg::gpio_vec_t            exp_out;
    gpio_pkg::gpio_vec_t            exp_oe;
    gpio_pkg::gpio_vec_t            exp_intr;
  } row_t;

  localparam int PinTimeout = 20;
  localparam logic [gpio_reg_pkg::RegBw-1:0] FullBe = '1;

  logic                           clk_i;
  logic                           rst_n_i;
  logic                           reg_we_i;
  logic                           reg_re_i;
  gpio_reg_pkg::reg_addr_t        reg_addr_i;
  gpio_reg_pkg::reg_word_t        reg_wdata_i;
  logic [gpio_reg_pkg::RegBw-1:0] reg_be_i;
  gpio_reg_pkg::reg_word_t        reg_rdata_o;
  logic                           reg_error_o;
  gpio_pkg::gpio_vec_t            gpio_i;
  gpio_pkg::gpio_vec_t            gpio_o;
  gpio_pkg::gpio_vec_t            gpio_oe_o;
  gpio_pkg::gpio_vec_t            intr_o;

  row_t        rows[$];
  logic [31:0] rng_state;

  // Reference model registers
  gpio_pkg::gpio_vec_t m_out;
  gpio_pkg::gpio_vec_t m_oe;
  gpio_pkg::gpio_vec_t m_state;
  gpio_pkg::gpio_vec_t m_en;
  gpio_pkg::gpio_vec_t m_rise;
  gpio_pkg::gpio_vec_t m_fall;
  gpio_pkg::gpio_vec_t m_pins;

  gpio_top #(
    .SyncStages (2)
  ) uut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_we_i    (reg_we_i),
    .reg_re_i    (reg_re_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_be_i    (reg_be_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_error_o (reg_error_o),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_oe_o   (gpio_oe_o),
    .intr_o      (intr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic expect_read(input gpio_reg_pkg::reg_addr_t addr,
                             output gpio_reg_pkg::reg_word_t word, output logic err);
    err = 1'b0;
    case (addr)
      gpio_reg_pkg::GPIO_INTR_STATE_OFFSET:       word = m_state;
      gpio_reg_pkg::GPIO_INTR_ENABLE_OFFSET:      word = m_en;
      gpio_reg_pkg::GPIO_INTR_TEST_OFFSET:        word = '0;
      gpio_reg_pkg::GPIO_DATA_IN_OFFSET:          word = m_pins;
      gpio_reg_pkg::GPIO_DIRECT_OUT_OFFSET:       word = m_out;
      gpio_reg_pkg::GPIO_MASKED_OUT_LOWER_OFFSET: word = {16'h0000, m_out[15:0]};
      gpio_reg_pkg::GPIO_MASKED_OUT_UPPER_OFFSET: word = {16'h0000, m_out[31:16]};
      gpio_reg_pkg::GPIO_DIRECT_OE_OFFSET:        word = m_oe;
      gpio_reg_pkg::GPIO_INTR_RISING_OFFSET:      word = m_rise;
      gpio_reg_pkg::GPIO_INTR_FALLING_OFFSET:     word = m_fall;
      default: begin
        word = '1;
        err  = 1'b1;
      end
    endcase
  endtask

  task automatic update_on_write(input gpio_reg_pkg::reg_addr_t addr,
                                 input gpio_reg_pkg::reg_word_t wdata,
                                 input logic [gpio_reg_pkg::RegBw-1:0] be, output logic err);
    gpio_reg_pkg::reg_word_t unused_word;
    logic [15:0]             mask;
    logic [15:0]             data;
    mask = wdata[31:16];
    data = wdata[15:0];
    expect_read(addr, unused_word, err);
    err = err | (be != FullBe);
    if (!err) begin
      case (addr)
        gpio_reg_pkg::GPIO_INTR_STATE_OFFSET:       m_state = m_state & ~wdata;
        gpio_reg_pkg::GPIO_INTR_ENABLE_OFFSET:      m_en = wdata;
        gpio_reg_pkg::GPIO_INTR_TEST_OFFSET:        m_state = m_state | wdata;
        gpio_reg_pkg::GPIO_DIRECT_OUT_OFFSET:       m_out = wdata;
        gpio_reg_pkg::GPIO_MASKED_OUT_LOWER_OFFSET:
          m_out[15:0] = (m_out[15:0] & ~mask) | (data & mask);
        gpio_reg_pkg::GPIO_MASKED_OUT_UPPER_OFFSET:
          m_out[31:16] = (m_out[31:16] & ~mask) | (data & mask);
        gpio_reg_pkg::GPIO_DIRECT_OE_OFFSET:        m_oe = wdata;
        gpio_reg_pkg::GPIO_INTR_RISING_OFFSET:      m_rise = wdata;
        gpio_reg_pkg::GPIO_INTR_FALLING_OFFSET:     m_fall = wdata;
        default: ;
      endcase
    end
  endtask

  // Edges only count on pins whose rising or falling enable is set
  task automatic update_on_pins(input gpio_pkg::gpio_vec_t pins);
    m_state = m_state | (pins & ~m_pins & m_rise) | (~pins & m_pins & m_fall);
    m_pins  = pins;
  endtask

  task automatic add_row(input op_e op, input gpio_reg_pkg::reg_addr_t addr,
                         input gpio_reg_pkg::reg_word_t wdata,
                         input logic [gpio_reg_pkg::RegBw-1:0] be,
                         input gpio_pkg::gpio_vec_t pins);
    row_t                    r;
    gpio_reg_pkg::reg_word_t word;
    logic                    err;
    r.op       = op;
    r.addr     = addr;
    r.wdata    = wdata;
    r.be       = be;
    r.pins     = pins;
    r.exp_out  = m_out;
    r.exp_oe   = m_oe;
    r.exp_intr = m_state & m_en;
    word       = '0;
    err        = 1'b0;
    case (op)
      OP_RD:   expect_read(addr, word, err);
      OP_WR:   update_on_write(addr, wdata, be, err);
      default: update_on_pins(pins);
    endcase
    r.exp_rdata = word;
    r.exp_err   = err;
    rows.push_back(r);
  endtask

  task automatic read_step(input gpio_reg_pkg::reg_addr_t addr);
    add_row(OP_RD, addr, '0, FullBe, '0);
  endtask

  task automatic write_step(input gpio_reg_pkg::reg_addr_t addr,
                            input gpio_reg_pkg::reg_word_t wdata);
    add_row(OP_WR, addr, wdata, FullBe, '0);
  endtask

  task automatic pin_step(input gpio_pkg::gpio_vec_t pins);
    add_row(OP_PIN, '0, '0, FullBe, pins);
  endtask

  task automatic build_table();
    rng_state = 32'd77;
    m_out     = '0;
    m_oe      = '0;
    m_state   = '0;
    m_en      = '0;
    m_rise    = '0;
    m_fall    = '0;
    m_pins    = '0;
    // Reset values of all mapped registers
    for (int i = 0; i < gpio_reg_pkg::NumRegs; i++) begin
      read_step(gpio_reg_pkg::reg_addr_t'(4 * i));
    end
    write_step(gpio_reg_pkg::GPIO_DIRECT_OUT_OFFSET, next_rand());
    read_step(gpio_reg_pkg::GPIO_DIRECT_OUT_OFFSET);
    write_step(gpio_reg_pkg::GPIO_DIRECT_OE_OFFSET, next_rand());
    read_step(gpio_reg_pkg::GPIO_DIRECT_OE_OFFSET);
    for (int i = 0; i < 8; i++) begin
      write_step((i % 2 == 1) ? gpio_reg_pkg::GPIO_MASKED_OUT_UPPER_OFFSET
                              : gpio_reg_pkg::GPIO_MASKED_OUT_LOWER_OFFSET, next_rand());
      read_step(gpio_reg_pkg::GPIO_MASKED_OUT_LOWER_OFFSET);
      read_step(gpio_reg_pkg::GPIO_MASKED_OUT_UPPER_OFFSET);
      read_step(gpio_reg_pkg::GPIO_DIRECT_OUT_OFFSET);
    end
    // Bus errors
    read_step(6'h28);
    read_step(6'h3c);
    write_step(6'h2c, 32'h1234_5678);
    add_row(OP_WR, gpio_reg_pkg::GPIO_DIRECT_OUT_OFFSET, 32'hdead_beef, 4'h3, '0);
    read_step(gpio_reg_pkg::GPIO_DIRECT_OUT_OFFSET);
    write_step(gpio_reg_pkg::GPIO_DATA_IN_OFFSET, 32'hffff_ffff);
    read_step(gpio_reg_pkg::GPIO_DATA_IN_OFFSET);
    // Pin edges into the interrupt state
    pin_step(32'ha5a5_0f0f);
    read_step(gpio_reg_pkg::GPIO_DATA_IN_OFFSET);
    write_step(gpio_reg_pkg::GPIO_INTR_RISING_OFFSET, 32'h0000_00ff);
    write_step(gpio_reg_pkg::GPIO_INTR_FALLING_OFFSET, 32'h0000_ff00);
    write_step(gpio_reg_pkg::GPIO_INTR_ENABLE_OFFSET, 32'h0000_0ff0);
    pin_step(32'hffff_ffff);
    read_step(gpio_reg_pkg::GPIO_INTR_STATE_OFFSET);
    pin_step(32'h0000_0000);
    read_step(gpio_reg_pkg::GPIO_INTR_STATE_OFFSET);
    write_step(gpio_reg_pkg::GPIO_INTR_STATE_OFFSET, 32'h0000_00f0);
    read_step(gpio_reg_pkg::GPIO_INTR_STATE_OFFSET);
    write_step(gpio_reg_pkg::GPIO_INTR_STATE_OFFSET, 32'hffff_ffff);
    read_step(gpio_reg_pkg::GPIO_INTR_STATE_OFFSET);
    // Software set through the test register
    write_step(gpio_reg_pkg::GPIO_INTR_TEST_OFFSET, 32'h8000_0001);
    read_step(gpio_reg_pkg::GPIO_INTR_TEST_OFFSET);
    read_step(gpio_reg_pkg::GPIO_INTR_STATE_OFFSET);
    write_step(gpio_reg_pkg::GPIO_INTR_ENABLE_OFFSET, 32'hffff_ffff);
    read_step(gpio_reg_pkg::GPIO_INTR_STATE_OFFSET);
  endtask

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input gpio_reg_pkg::reg_word_t got,
                            input gpio_reg_pkg::reg_word_t exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_error(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_pins(input string name, input gpio_pkg::gpio_vec_t got,
                            input gpio_pkg::gpio_vec_t exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // Poll DATA_IN until the synchronizer delivers the new pin value
  task automatic wait_data_in(input gpio_pkg::gpio_vec_t expected);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < PinTimeout) begin
      @(posedge clk_i);
      reg_re_i   <= 1'b1;
      reg_addr_i <= gpio_reg_pkg::GPIO_DATA_IN_OFFSET;
      @(negedge clk_i);
      seen = (reg_rdata_o === expected);
      cycles++;
    end
    @(posedge clk_i);
    reg_re_i <= 1'b0;
    if (!seen) begin
      fail_now("Timeout: DATA_IN never showed the value driven on gpio_i");
    end
  endtask

  initial begin
    rst_n_i     <= 1'b0;
    reg_we_i    <= 1'b0;
    reg_re_i    <= 1'b0;
    reg_addr_i  <= '0;
    reg_wdata_i <= '0;
    reg_be_i    <= '0;
    gpio_i      <= '0;
    build_table();
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    foreach (rows[i]) begin
      @(posedge clk_i);
      reg_we_i    <= (rows[i].op == OP_WR);
      reg_re_i    <= (rows[i].op == OP_RD);
      reg_addr_i  <= rows[i].addr;
      reg_wdata_i <= rows[i].wdata;
      reg_be_i    <= rows[i].be;
      if (rows[i].op == OP_PIN) begin
        gpio_i <= rows[i].pins;
      end
      @(negedge clk_i);
      check_pins("gpio_o", gpio_o, rows[i].exp_out);
      check_pins("gpio_oe_o", gpio_oe_o, rows[i].exp_oe);
      check_pins("intr_o", intr_o, rows[i].exp_intr);
      check_error("reg_error_o", reg_error_o, rows[i].exp_err);
      if (rows[i].op == OP_RD) begin
        check_word("reg_rdata_o", reg_rdata_o, rows[i].exp_rdata);
      end
      if (rows[i].op == OP_PIN) begin
        wait_data_in(rows[i].pins);
      end
    end
    @(posedge clk_i);
    reg_we_i <= 1'b0;
    reg_re_i <= 1'b0;
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hw/gpio_pkg.sv
hw/gpio_reg_pkg.sv
hw/gpio_reg_if.sv
hw/gpio_reg_decode.sv
hw/gpio_out_ctrl.sv
hw/gpio_in_sync.sv
hw/gpio_intr.sv
hw/gpio_top.sv
testbench/tb_gpio_top.sv

// File: Makefile
TOP = tb_gpio_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module gpio_top

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
